// File: include/loader_consts.svh
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// serial bit time in system clocks
// five clocks per bit, same step as the host model
`define LDR_CLKS_PER_BIT 5

// program memory depth in 32-bit words
`define LDR_MEM_WORDS 32

// word address width, log2 of the depth
`define LDR_ADDR_W 5

`endif

// File: src/loader_pkg.sv
`include "loader_consts.svh"

package loader_pkg;

  // loader FSM states
  // length header, program bytes, memory write, checksum reply, idle after load
  typedef enum logic [2:0] {
    LDR_LEN,
    LDR_PROG,
    LDR_WRITE,
    LDR_CSUM,
    LDR_DONE
  } ldr_state_e;

  // one word write toward program memory
  typedef struct packed {
    logic [`LDR_ADDR_W-1:0] addr;
    logic [31:0]            data;
  } mem_wr_s;

  // received byte, strobe high for one cycle per good frame
  typedef struct packed {
    logic [7:0] data;
    logic       strobe;
  } rx_byte_s;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ns
`include "loader_consts.svh"

module uart_rx
  import loader_pkg::*;
(
  input  logic     sys_clock,
  input  logic     rst_n,
  input  logic     rxd,
  output rx_byte_s rx_byte,
  output logic     frame_err
);

  localparam int DIV_W = $clog2(`LDR_CLKS_PER_BIT);
  localparam logic [DIV_W-1:0] DIV_FULL = DIV_W'(`LDR_CLKS_PER_BIT - 1);
  localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(`LDR_CLKS_PER_BIT / 2);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_WAIT
  } rx_state_e;

  rx_state_e        state;
  logic [1:0]       sync;
  logic             rxd_s;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;

  // two flop synchronizer, idle line is high
  always_ff @(posedge sys_clock or negedge rst_n) begin
    if (!rst_n) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rxd};
    end
  end

  assign rxd_s = sync[1];

  // data bits arrive LSB first, shift in from the top
  always_ff @(posedge sys_clock) begin
    if (state == RX_DATA && div_cnt == '0) begin
      shreg <= {rxd_s, shreg[7:1]};
    end
  end

  always_ff @(posedge sys_clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      div_cnt   <= '0;
      bit_idx   <= '0;
      rx_byte   <= '0;
      frame_err <= 1'b0;
    end else begin
      // strobe is a single cycle pulse
      rx_byte.strobe <= 1'b0;
      case (state)
        RX_IDLE: begin
          // falling start edge, go to middle of start bit
          if (!rxd_s) begin
            div_cnt <= DIV_HALF;
            state   <= RX_START;
          end
        end
        RX_START: begin
          if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
          end else if (!rxd_s) begin
            div_cnt <= DIV_FULL;
            bit_idx <= '0;
            state   <= RX_DATA;
          end else begin
            // glitch, not a real start bit
            state <= RX_IDLE;
          end
        end
        RX_DATA: begin
          if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
          end else begin
            div_cnt <= DIV_FULL;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
          end else if (rxd_s) begin
            rx_byte.data   <= shreg;
            rx_byte.strobe <= 1'b1;
            state          <= RX_IDLE;
          end else begin
            // bad stop bit, byte is dropped
            frame_err <= 1'b1;
            state     <= RX_WAIT;
          end
        end
        RX_WAIT: begin
          // hold off until the line goes back to idle
          if (rxd_s) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ns
`include "loader_consts.svh"

module uart_tx (
  input  logic       sys_clock,
  input  logic       rst_n,
  input  logic [7:0] tx_data,
  input  logic       tx_req,
  output logic       tx_ack,
  output logic       txd
);

  localparam int DIV_W = $clog2(`LDR_CLKS_PER_BIT);
  localparam logic [DIV_W-1:0] DIV_FULL = DIV_W'(`LDR_CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_ACK
  } tx_state_e;

  tx_state_e        state;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  // data bits then stop bit, start bit goes out directly
  logic [8:0]       shreg;

  always_ff @(posedge sys_clock) begin
    if (state == TX_IDLE && tx_req) begin
      shreg <= {1'b1, tx_data};
    end else if (state == TX_SEND && div_cnt == '0) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  always_ff @(posedge sys_clock or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      tx_ack  <= 1'b0;
      txd     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          // accept a byte, start bit begins now
          if (tx_req) begin
            txd     <= 1'b0;
            div_cnt <= DIV_FULL;
            bit_cnt <= 4'd9;
            state   <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
          end else if (bit_cnt == 4'd0) begin
            // stop bit finished, 10 bit times after req
            tx_ack <= 1'b1;
            state  <= TX_ACK;
          end else begin
            txd     <= shreg[0];
            div_cnt <= DIV_FULL;
            bit_cnt <= bit_cnt - 4'd1;
          end
        end
        TX_ACK: begin
          // four phase return, ack falls after req
          if (!tx_req) begin
            tx_ack <= 1'b0;
            state  <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

// File: src/boot_loader.sv
`timescale 1ns/1ns
`include "loader_consts.svh"

module boot_loader
  import loader_pkg::*;
(
  input  logic       sys_clock,
  input  logic       rst_n,
  input  rx_byte_s   rx_byte,
  output mem_wr_s    wr,
  output logic       wr_req,
  input  logic       wr_ack,
  output logic [7:0] tx_data,
  output logic       tx_req,
  input  logic       tx_ack,
  output logic       done
);

  localparam logic [29:0] MEM_WORDS = 30'(`LDR_MEM_WORDS);

  ldr_state_e  state;
  // byte position inside the length or the current word
  logic [1:0]  byte_cnt;
  // shared LSB first assembly for length and words
  logic [31:0] shift;
  logic [31:0] word_next;
  // program bytes still expected, leftovers included
  logic [31:0] bytes_left;
  // full words still expected
  logic [29:0] words_left;
  // word index, may run past the memory depth
  logic [29:0] word_idx;
  logic [31:0] csum;
  // checksum byte being sent
  logic [1:0]  tx_idx;
  logic        in_words;
  logic        take_byte;

  assign word_next = {rx_byte.data, shift[31:8]};
  assign in_words  = (words_left != '0);

  // bytes that go into the shift word
  assign take_byte = rx_byte.strobe &&
                     (state == LDR_LEN || state == LDR_DONE ||
                      (state == LDR_PROG && in_words));

  // checksum goes out LSB first
  assign tx_data = csum[8*tx_idx +: 8];

  always_ff @(posedge sys_clock) begin
    if (take_byte) begin
      shift <= word_next;
    end
  end

  // write payload latched with the fourth byte of a word
  always_ff @(posedge sys_clock) begin
    if (take_byte && state == LDR_PROG && byte_cnt == 2'd3) begin
      wr.addr <= word_idx[`LDR_ADDR_W-1:0];
      wr.data <= word_next;
    end
  end

  always_ff @(posedge sys_clock or negedge rst_n) begin
    if (!rst_n) begin
      state      <= LDR_LEN;
      byte_cnt   <= '0;
      bytes_left <= '0;
      words_left <= '0;
      word_idx   <= '0;
      csum       <= '0;
      tx_idx     <= '0;
      wr_req     <= 1'b0;
      tx_req     <= 1'b0;
      done       <= 1'b0;
    end else begin
      case (state)
        LDR_LEN, LDR_DONE: begin
          // a new header after done restarts the load
          if (rx_byte.strobe) begin
            done     <= 1'b0;
            byte_cnt <= byte_cnt + 2'd1;
            state    <= LDR_LEN;
            if (byte_cnt == 2'd3) begin
              bytes_left <= word_next;
              // low two bits dropped, leftovers skipped later
              words_left <= word_next[31:2];
              word_idx   <= '0;
              csum       <= '0;
              tx_idx     <= '0;
              // zero length replies at once
              state <= (word_next == '0) ? LDR_CSUM : LDR_PROG;
            end
          end
        end
        LDR_PROG: begin
          if (rx_byte.strobe) begin
            bytes_left <= bytes_left - 32'd1;
            if (in_words) begin
              byte_cnt <= byte_cnt + 2'd1;
              if (byte_cnt == 2'd3) begin
                csum       <= csum + word_next;
                words_left <= words_left - 30'd1;
                if (word_idx < MEM_WORDS) begin
                  wr_req <= 1'b1;
                  state  <= LDR_WRITE;
                end else begin
                  // past the memory, only summed
                  word_idx <= word_idx + 30'd1;
                  if (bytes_left == 32'd1) begin
                    state <= LDR_CSUM;
                  end
                end
              end
            end else if (bytes_left == 32'd1) begin
              // last leftover byte
              state <= LDR_CSUM;
            end
          end
        end
        LDR_WRITE: begin
          // memory acked, release req and move on
          if (wr_ack) begin
            wr_req   <= 1'b0;
            word_idx <= word_idx + 30'd1;
            state    <= (bytes_left == '0) ? LDR_CSUM : LDR_PROG;
          end
        end
        LDR_CSUM: begin
          // next byte only once the previous ack is gone
          if (!tx_req && !tx_ack) begin
            tx_req <= 1'b1;
          end else if (tx_req && tx_ack) begin
            tx_req <= 1'b0;
            tx_idx <= tx_idx + 2'd1;
            if (tx_idx == 2'd3) begin
              done  <= 1'b1;
              state <= LDR_DONE;
            end
          end
        end
        default: state <= LDR_LEN;
      endcase
    end
  end

endmodule

// File: src/prog_mem.sv
`timescale 1ns/1ns
`include "loader_consts.svh"

module prog_mem
  import loader_pkg::*;
(
  input  logic                   sys_clock,
  input  logic                   rst_n,
  input  mem_wr_s                wr,
  input  logic                   wr_req,
  output logic                   wr_ack,
  input  logic [`LDR_ADDR_W-1:0] rd_addr,
  output logic [31:0]            rd_data
);

  logic [31:0] mem [`LDR_MEM_WORDS];

  always_ff @(posedge sys_clock or negedge rst_n) begin
    if (!rst_n) begin
      // memory starts out all zero
      for (int i = 0; i < `LDR_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
      wr_ack <= 1'b0;
    end else if (wr_req && !wr_ack) begin
      // rising req, write and ack next cycle
      mem[wr.addr] <= wr.data;
      wr_ack       <= 1'b1;
    end else if (!wr_req) begin
      wr_ack <= 1'b0;
    end
  end

  // fetch port for the processor, no read latency
  assign rd_data = mem[rd_addr];

endmodule

// File: src/uart_boot_top.sv
`timescale 1ns/1ns
`include "loader_consts.svh"

module uart_boot_top
  import loader_pkg::*;
(
  input  logic                   sys_clock,
  input  logic                   rst_n,
  input  logic                   rxd,
  output logic                   txd,
  input  logic [`LDR_ADDR_W-1:0] rd_addr,
  output logic [31:0]            rd_data,
  output logic                   done,
  output logic                   frame_err
);

  rx_byte_s   rx_byte;
  mem_wr_s    wr;
  logic       wr_req;
  logic       wr_ack;
  logic [7:0] tx_data;
  logic       tx_req;
  logic       tx_ack;

  // serial in
  uart_rx u_rx (
    .sys_clock (sys_clock),
    .rst_n     (rst_n),
    .rxd       (rxd),
    .rx_byte   (rx_byte),
    .frame_err (frame_err)
  );

  // header parse, word packing, checksum
  boot_loader u_loader (
    .sys_clock (sys_clock),
    .rst_n     (rst_n),
    .rx_byte   (rx_byte),
    .wr        (wr),
    .wr_req    (wr_req),
    .wr_ack    (wr_ack),
    .tx_data   (tx_data),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .done      (done)
  );

  prog_mem u_mem (
    .sys_clock (sys_clock),
    .rst_n     (rst_n),
    .wr        (wr),
    .wr_req    (wr_req),
    .wr_ack    (wr_ack),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  // checksum reply
  uart_tx u_tx (
    .sys_clock (sys_clock),
    .rst_n     (rst_n),
    .tx_data   (tx_data),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .txd       (txd)
  );

endmodule

// File: bench/tb_uart_boot.sv
`timescale 1ns/1ns
`include "loader_consts.svh"

module tb_uart_boot;

  localparam int CLK_NS     = 20;
  localparam int BIT_CLKS   = `LDR_CLKS_PER_BIT;
  localparam int ADDR_W     = `LDR_ADDR_W;
  localparam int DATA_BYTES = 1024;

  logic              sys_clock;
  logic              rst_n;
  logic              rxd;
  logic              txd;
  logic [ADDR_W-1:0] rd_addr;
  logic [31:0]       rd_data;
  logic              done;
  logic              frame_err;

  // raw stream bytes from the data file
  logic [7:0]  tdata [DATA_BYTES];
  // expected memory image, kept across loads
  logic [31:0] model [`LDR_MEM_WORDS];
  logic [15:0] lfsr;
  logic [31:0] csum_got;
  int          wd_ns;
  logic        wd_armed;

  uart_boot_top u_uart_boot_top (
    .sys_clock (sys_clock),
    .rst_n     (rst_n),
    .rxd       (rxd),
    .txd       (txd),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .done      (done),
    .frame_err (frame_err)
  );

  always #(CLK_NS / 2) sys_clock = ~sys_clock;

  // right shift galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // idle gap of 0 to 7 bit times, one lfsr step per bit
  task automatic pick_gap(output int n);
    n = 0;
    for (int i = 0; i < 3; i++) begin
      n = n | (int'(lfsr[0]) << i);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "compare failed");
    end
  endtask

  // called on a falling edge, holds the line one bit time
  task automatic drive_bit(input logic v);
    rxd = v;
    repeat (BIT_CLKS) @(negedge sys_clock);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic bad_stop);
    int gap;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(!bad_stop);
    pick_gap(gap);
    repeat (gap) drive_bit(1'b1);
  endtask

  // four reply bytes, LSB first, sampled mid-bit
  task automatic recv_csum();
    logic [7:0] b;
    csum_got = '0;
    for (int k = 0; k < 4; k++) begin
      @(negedge txd);
      repeat (BIT_CLKS / 2 + 1) @(negedge sys_clock);
      check_equal("txd start bit", 32'(txd), 32'h0);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge sys_clock);
        b[i] = txd;
      end
      repeat (BIT_CLKS) @(negedge sys_clock);
      check_equal("txd stop bit", 32'(txd), 32'h1);
      csum_got[8*k +: 8] = b;
    end
  endtask

  task automatic run_load(input int start, input int count);
    logic [31:0] len;
    logic [31:0] word;
    logic [31:0] sum;
    int          nwords;
    len = {tdata[start + 3], tdata[start + 2], tdata[start + 1], tdata[start]};
    // leftover bytes below a full word are dropped
    nwords = int'(len >> 2);
    sum = '0;
    for (int w = 0; w < nwords; w++) begin
      word = {tdata[start + 4*w + 7], tdata[start + 4*w + 6],
              tdata[start + 4*w + 5], tdata[start + 4*w + 4]};
      sum = sum + word;
      // words past the depth only count in the sum
      if (w < `LDR_MEM_WORDS) begin
        model[w] = word;
      end
    end
    fork
      for (int i = 0; i < count; i++) begin
        send_byte(tdata[start + i], 1'b0);
      end
      recv_csum();
    join
    wait (done);
    @(negedge sys_clock);
    check_equal("checksum", csum_got, sum);
    check_equal("frame_err", 32'(frame_err), 32'h0);
    for (int a = 0; a < `LDR_MEM_WORDS; a++) begin
      rd_addr = ADDR_W'(a);
      @(posedge sys_clock);
      check_equal($sformatf("rd_data[%0d]", a), rd_data, model[a]);
      @(negedge sys_clock);
    end
  endtask

  initial begin
    int p;
    int total;
    sys_clock = 1'b0;
    rst_n     = 1'b0;
    rxd       = 1'b1;
    rd_addr   = '0;
    wd_armed  = 1'b0;
    lfsr      = 16'd64746;
    for (int a = 0; a < `LDR_MEM_WORDS; a++) begin
      model[a] = '0;
    end
    $readmemh("bench/uart_boot_testdata.hex", tdata);
    // walk the blocks once, byte total sizes the watchdog
    p = 0;
    total = 0;
    while (p < DATA_BYTES - 1 && tdata[p] !== 8'h00) begin
      if (tdata[p] !== 8'h01 && tdata[p] !== 8'h02) begin
        $display("data file holds an unknown test kind at byte %0d", p);
        $display("FAIL: see errors above");
        $fatal(1, "bad data file");
      end else begin
        total += int'(tdata[p + 1]);
        p += 2 + int'(tdata[p + 1]);
      end
    end
    // 10 bits per byte, each up to 8 bit spans with the idle gap
    wd_ns = (total * 10 * 8 * BIT_CLKS + 2000) * CLK_NS;
    wd_armed = 1'b1;
    repeat (2) @(negedge sys_clock);
    rst_n = 1'b1;
    check_equal("txd", 32'(txd), 32'h1);
    check_equal("done", 32'(done), 32'h0);
    check_equal("frame_err", 32'(frame_err), 32'h0);
    p = 0;
    while (tdata[p] !== 8'h00) begin
      if (tdata[p] == 8'h01) begin
        run_load(p + 2, int'(tdata[p + 1]));
      end else begin
        // frames with a zero stop bit, then idle line
        for (int i = 0; i < int'(tdata[p + 1]); i++) begin
          send_byte(tdata[p + 2 + i], 1'b1);
        end
        drive_bit(1'b1);
        drive_bit(1'b1);
        check_equal("frame_err", 32'(frame_err), 32'h1);
      end
      p += 2 + int'(tdata[p + 1]);
    end
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    wait (wd_armed);
    #(wd_ns);
    $display("watchdog expired, the load never finished");
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

endmodule

// File: uart_boot_top.f
+incdir+include
src/loader_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/boot_loader.sv
src/prog_mem.sv
src/uart_boot_top.sv
bench/tb_uart_boot.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_boot
FILELIST   := uart_boot_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary's exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/uart_boot_testdata.hex
// block: test kind (01 load, 02 bad stop bit, 00 end), byte count, then the bytes
// a load stream opens with its 4-byte length, LSB first, then the program bytes
// basic load, 12 words
01 34 30 00 00 00
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
// sum wraps past 2^32
01 10 0C 00 00 00
FF FF FF FF FF FF FF FF 03 00 00 00
// 40 words, 8 past the memory depth
01 A4 A0 00 00 00
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F
50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
// 10 bytes, two leftovers, then an empty load
01 0E 0A 00 00 00
11 22 33 44 55 66 77 88 99 AA
01 04 00 00 00 00
02 01 5A
00
